// ==== Makefile ====
# Verilator simulation of the store buffer subsystem

VERILATOR ?= verilator
TOP ?= tb_store_subsystem
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= All checks passed

.PHONY: sim clean

# The run passes only when the pass message shows up in the simulation output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== src.f ====
verilog/stbuf_pkg.sv
verilog/rr_arbiter.sv
verilog/store_bypass.sv
verilog/sync_store_tracker.sv
verilog/store_buffer.sv
verilog/store_subsystem_top.sv
testbench/tb_store_subsystem.sv

// ==== testbench/tb_store_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_store_subsystem;
	import stbuf_pkg::*;

	localparam int RESET_CYCLES = 10;
	localparam int MAX_RSP_DELAY = 6;
	localparam int NUM_TESTS = 5;
	// Longest test issues one request per strand, each answered after the longest delay
	localparam int TEST_CYCLES = 40 + NUM_STRANDS * (MAX_RSP_DELAY + 4);
	localparam int CYCLE_LIMIT = RESET_CYCLES + NUM_TESTS * TEST_CYCLES;

	logic clk = 1'b0;
	logic reset;
	store_cmd_t cmd;
	logic [STRAND_W-1:0] lookup_strand;
	logic [TAG_W-1:0] lookup_tag;
	logic [SET_W-1:0] lookup_set;
	logic l2req_valid;
	l2_req_t l2req;
	logic l2req_ready;
	l2_rsp_t l2rsp = '0;
	logic rollback;
	logic [NUM_STRANDS-1:0] resume_strands;
	logic store_update;
	logic [SET_W-1:0] store_update_set;
	logic [LINE_W-1:0] bypass_data;
	logic [LINE_BYTES-1:0] bypass_mask;

	// Every request that L2 took, in order of acceptance
	l2_req_t accepted [$];
	int read_idx = 0;
	// Strands with a response still owed by the L2 model, and cycles left until it is sent
	logic [NUM_STRANDS-1:0] pending;
	int due [NUM_STRANDS];
	// Status and update flag that the L2 model puts into its next responses
	logic rsp_status = 1'b0;
	logic rsp_update = 1'b0;

	int cycle_count = 0;
	int check_count = 0;
	int error_count = 0;
	int test_errors = 0;

	store_subsystem_top DUT
	(
		.clk(clk),
		.reset(reset),
		.cmd_i(cmd),
		.lookup_strand_i(lookup_strand),
		.lookup_tag_i(lookup_tag),
		.lookup_set_i(lookup_set),
		.l2req_valid_o(l2req_valid),
		.l2req_o(l2req),
		.l2req_ready_i(l2req_ready),
		.l2rsp_i(l2rsp),
		.rollback_o(rollback),
		.resume_strands_o(resume_strands),
		.store_update_o(store_update),
		.store_update_set_o(store_update_set),
		.bypass_data_o(bypass_data),
		.bypass_mask_o(bypass_mask)
	);

	always #4 clk = ~clk;

	// L2 model, each accepted request gets one response after a random delay
	// and at most one response goes out per cycle, lowest strand first
	always @(posedge clk)
	begin : l2_responder
		int fire;
		fire = -1;
		if (reset)
		begin
			l2rsp <= '0;
			pending = '0;
			accepted.delete();
		end
		else
		begin
			for (int s = NUM_STRANDS - 1; s >= 0; s--)
			begin
				if (pending[s] && due[s] == 0)
					fire = s;
			end
			if (fire >= 0)
			begin
				l2rsp <= '{valid: 1'b1, status: rsp_status, unit: UNIT_STBUF,
					strand: STRAND_W'(fire), update: rsp_update};
				pending[STRAND_W'(fire)] = 1'b0;
			end
			else
				l2rsp <= '0;
			for (int s = 0; s < NUM_STRANDS; s++)
			begin
				if (pending[s] && due[s] > 0)
					due[s]--;
			end
			// A transfer happens on a cycle where valid and ready are both high
			if (l2req_valid && l2req_ready)
			begin
				accepted.push_back(l2req);
				pending[l2req.strand] = 1'b1;
				due[l2req.strand] = $urandom_range(MAX_RSP_DELAY - 1, 0);
			end
		end
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT)
		begin
			$display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Checks failed");
			$finish;
		end
	end

	task automatic compare_req(input l2_req_t got, input l2_req_t exp, input string what);
		check_count++;
		if (got !== exp)
		begin
			error_count++;
			$display("error at %0t: %s, got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compare_line(input logic [LINE_W-1:0] got_data,
		input logic [LINE_BYTES-1:0] got_mask, input logic [LINE_W-1:0] exp_data,
		input logic [LINE_BYTES-1:0] exp_mask, input string what);
		check_count++;
		if (got_data !== exp_data || got_mask !== exp_mask)
		begin
			error_count++;
			$display("error at %0t: %s, got %h/%h expected %h/%h", $time, what,
				got_data, got_mask, exp_data, exp_mask);
		end
	endtask

	task automatic compare_strands(input logic [NUM_STRANDS-1:0] got,
		input logic [NUM_STRANDS-1:0] exp, input string what);
		check_count++;
		if (got !== exp)
		begin
			error_count++;
			$display("error at %0t: %s, got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic compare_set_index(input logic [SET_W-1:0] got, input logic [SET_W-1:0] exp,
		input string what);
		check_count++;
		if (got !== exp)
		begin
			error_count++;
			$display("error at %0t: %s, got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compare_flag(input logic got, input logic exp, input string what);
		check_count++;
		if (got !== exp)
		begin
			error_count++;
			$display("error at %0t: %s, got %b expected %b", $time, what, got, exp);
		end
	endtask

	function automatic store_cmd_t random_cmd(input logic is_flush, input logic sync,
		input logic [STRAND_W-1:0] strand);
		store_cmd_t c;
		c.store = !is_flush;
		c.flush = is_flush;
		c.synchronized = sync;
		c.strand = strand;
		c.tag = TAG_W'($urandom());
		c.set = SET_W'($urandom());
		c.data = {$urandom(), $urandom(), $urandom(), $urandom()};
		c.mask = LINE_BYTES'($urandom());
		return c;
	endfunction

	// L2 sees the line address as tag then set, and the command's own data and mask
	function automatic l2_req_t expect_req(input store_cmd_t c, input l2_op_e op);
		l2_req_t r;
		r.unit = UNIT_STBUF;
		r.strand = c.strand;
		r.op = op;
		r.address = {c.tag, c.set};
		r.data = c.data;
		r.mask = c.mask;
		return r;
	endfunction

	// Returns right after the clock edge where the DUT took the command
	task automatic send_cmd(input store_cmd_t c);
		@(posedge clk);
		cmd <= c;
		@(posedge clk);
		cmd <= '0;
	endtask

	// Returns in the middle of the cycle where the registered bypass result is visible
	task automatic send_lookup(input logic [STRAND_W-1:0] strand, input logic [TAG_W-1:0] tag,
		input logic [SET_W-1:0] set);
		@(posedge clk);
		lookup_strand <= strand;
		lookup_tag <= tag;
		lookup_set <= set;
		@(posedge clk);
		@(negedge clk);
	endtask

	task automatic set_ready(input logic value);
		@(posedge clk);
		l2req_ready <= value;
	endtask

	task automatic wait_accept(output l2_req_t req);
		while (accepted.size() <= read_idx)
			@(negedge clk);
		req = accepted[read_idx];
		read_idx++;
	endtask

	// Stops in the cycle where the response for this strand is on the port
	task automatic wait_response(input logic [STRAND_W-1:0] strand);
		@(negedge clk);
		while (!(l2rsp.valid && l2rsp.strand == strand))
			@(negedge clk);
	endtask

	task automatic wait_idle();
		@(negedge clk);
		while (pending != '0 || l2req_valid)
			@(negedge clk);
		repeat (2) @(negedge clk);
	endtask

	task automatic finish_test(input string name);
		$display("test %s finished with %0d errors", name, error_count - test_errors);
		test_errors = error_count;
	endtask

	task automatic test_issue();
		store_cmd_t c;
		l2_req_t req;
		set_ready(1'b1);
		c = random_cmd(1'b0, 1'b0, STRAND_W'(0));
		send_cmd(c);
		wait_accept(req);
		compare_req(req, expect_req(c, L2OP_STORE), "store request");
		wait_idle();
		c = random_cmd(1'b1, 1'b0, STRAND_W'(0));
		send_cmd(c);
		wait_accept(req);
		compare_req(req, expect_req(c, L2OP_FLUSH), "flush request");
		wait_idle();
		finish_test("issue");
	endtask

	task automatic test_bypass();
		store_cmd_t c;
		l2_req_t req;
		// Ready stays low so the entry is still pending during the lookups
		set_ready(1'b0);
		c = random_cmd(1'b0, 1'b0, STRAND_W'(3));
		send_cmd(c);
		send_lookup(STRAND_W'(3), c.tag, c.set);
		compare_line(bypass_data, bypass_mask, c.data, c.mask, "same strand lookup");
		send_lookup(STRAND_W'(2), c.tag, c.set);
		compare_line(bypass_data, bypass_mask, '0, '0, "other strand lookup");
		send_lookup(STRAND_W'(3), c.tag, SET_W'(c.set + 1));
		compare_line(bypass_data, bypass_mask, '0, '0, "other address lookup");
		set_ready(1'b1);
		wait_accept(req);
		compare_req(req, expect_req(c, L2OP_STORE), "bypassed store request");
		wait_idle();
		finish_test("bypass");
	endtask

	task automatic test_full_rollback();
		store_cmd_t c;
		store_cmd_t second;
		l2_req_t req;
		rsp_update = 1'b1;
		set_ready(1'b0);
		c = random_cmd(1'b0, 1'b0, STRAND_W'(1));
		send_cmd(c);
		@(negedge clk);
		compare_flag(rollback, 1'b0, "rollback on free strand");
		second = random_cmd(1'b0, 1'b0, STRAND_W'(1));
		send_cmd(second);
		@(negedge clk);
		compare_flag(rollback, 1'b1, "rollback on occupied strand");
		set_ready(1'b1);
		wait_accept(req);
		compare_req(req, expect_req(c, L2OP_STORE), "first store request");
		// The update outputs follow the response in the same cycle
		wait_response(STRAND_W'(1));
		compare_flag(store_update, 1'b1, "store update");
		compare_set_index(store_update_set, c.set, "store update set");
		@(negedge clk);
		compare_strands(resume_strands, 4'b0010, "resume after full rollback");
		wait_idle();
		rsp_update = 1'b0;
		finish_test("full_rollback");
	endtask

	task automatic test_sync_store();
		store_cmd_t c;
		l2_req_t req;
		int seen;
		rsp_status = 1'b1;
		set_ready(1'b1);
		c = random_cmd(1'b0, 1'b1, STRAND_W'(2));
		send_cmd(c);
		@(negedge clk);
		compare_flag(rollback, 1'b1, "first sync store rollback");
		wait_accept(req);
		compare_req(req, expect_req(c, L2OP_STORE_SYNC), "sync store request");
		wait_response(STRAND_W'(2));
		@(negedge clk);
		compare_strands(resume_strands, 4'b0100, "resume after sync store");
		// The retry is answered from the stored status and never reaches L2
		seen = accepted.size();
		send_cmd(c);
		@(negedge clk);
		compare_flag(rollback, 1'b0, "sync retry rollback");
		compare_line(bypass_data, bypass_mask, {LINE_WORDS{32'h0000_0001}}, '1,
			"sync store status");
		repeat (4)
		begin
			@(negedge clk);
			compare_flag(l2req_valid, 1'b0, "request after sync retry");
		end
		compare_flag(accepted.size() != seen, 1'b0, "second sync request");
		wait_idle();
		rsp_status = 1'b0;
		finish_test("sync_store");
	endtask

	task automatic test_round_robin();
		store_cmd_t cmds [NUM_STRANDS];
		l2_req_t req;
		logic [STRAND_W-1:0] strand;
		set_ready(1'b0);
		for (int s = 0; s < NUM_STRANDS; s++)
		begin
			cmds[s] = random_cmd(1'b0, 1'b0, STRAND_W'(s));
			send_cmd(cmds[s]);
		end
		// Strand 0 requests alone for two cycles, so its grant is the one that stalls
		repeat (4)
		begin
			@(negedge clk);
			compare_flag(l2req_valid, 1'b1, "stalled valid");
			compare_req(l2req, expect_req(cmds[0], L2OP_STORE), "stalled request");
		end
		// Once released, grants move on from the stalled strand one strand at a time
		strand = '0;
		set_ready(1'b1);
		for (int k = 0; k < NUM_STRANDS; k++)
		begin
			wait_accept(req);
			compare_req(req, expect_req(cmds[strand], L2OP_STORE), "round robin grant");
			strand = strand + 1'b1;
		end
		wait_idle();
		finish_test("round_robin");
	endtask

	initial
	begin
		void'($urandom(32'h804e_562f));
		reset <= 1'b1;
		cmd <= '0;
		lookup_strand <= '0;
		lookup_tag <= '0;
		lookup_set <= '0;
		l2req_ready <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		test_issue();
		test_bypass();
		test_full_rollback();
		test_sync_store();
		test_round_robin();
		$display("%0d tests, %0d checks, %0d errors", NUM_TESTS, check_count, error_count);
		if (error_count == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/rr_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter
(
	input wire logic clk,
	input wire logic reset,
	input wire logic [stbuf_pkg::NUM_STRANDS-1:0] request_i,
	input wire logic accept_i,
	output logic [stbuf_pkg::NUM_STRANDS-1:0] grant_oh_o
);
	import stbuf_pkg::*;

	// One-hot marker of the strand that has the highest priority
	logic [NUM_STRANDS-1:0] prio_q;
	// A grant that was not accepted is held so the L2 request stays stable
	logic hold_q;
	logic [NUM_STRANDS-1:0] held_q;
	logic [2*NUM_STRANDS-1:0] double_req;
	logic [2*NUM_STRANDS-1:0] double_grant;
	logic [NUM_STRANDS-1:0] rr_grant;

	// The subtraction finds the first requester at or above the priority marker,
	// wrapping around through the upper copy of the request vector
	always_comb
	begin
		double_req = {request_i, request_i};
		double_grant = double_req & ~(double_req - {{NUM_STRANDS{1'b0}}, prio_q});
		rr_grant = double_grant[NUM_STRANDS-1:0] | double_grant[2*NUM_STRANDS-1:NUM_STRANDS];
	end

	assign grant_oh_o = (hold_q && |(held_q & request_i)) ? held_q : rr_grant;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			prio_q <= NUM_STRANDS'(1);
			hold_q <= 1'b0;
			held_q <= '0;
		end
		else
		begin
			// Move the priority just past the strand that won
			if (accept_i && |grant_oh_o)
				prio_q <= {grant_oh_o[NUM_STRANDS-2:0], grant_oh_o[NUM_STRANDS-1]};
			hold_q <= |grant_oh_o && !accept_i;
			held_q <= grant_oh_o;
		end
	end

	a_grant_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot0(grant_oh_o));

	// The buffer keeps requesting an entry until L2 takes it, so a stalled grant must not move
	a_grant_stable: assert property (@(posedge clk) disable iff (reset)
		(|grant_oh_o && !accept_i) |=> (grant_oh_o == $past(grant_oh_o)));

endmodule

`default_nettype wire

// ==== verilog/stbuf_pkg.sv ====
`default_nettype none

package stbuf_pkg;

	// Four hardware strands share the store buffer, one entry each
	localparam int NUM_STRANDS = 4;
	localparam int STRAND_W = 2;

	// A line address is the L1 tag followed by the set index
	localparam int TAG_W = 20;
	localparam int SET_W = 6;
	localparam int ADDR_W = TAG_W + SET_W;

	// Line geometry, the byte mask carries one bit per byte of the line
	localparam int LINE_BYTES = 16;
	localparam int LINE_W = LINE_BYTES * 8;

	// Sync store status is returned in bit 0 of every word of the line
	localparam int WORD_W = 32;
	localparam int LINE_WORDS = LINE_W / WORD_W;

	// Operations the store buffer sends to L2
	typedef enum logic [2:0]
	{
		L2OP_STORE = 3'd1,
		L2OP_FLUSH = 3'd2,
		L2OP_STORE_SYNC = 3'd3
	} l2_op_e;

	// Requesting units on the L2 port, responses are routed back by this field
	typedef enum logic [1:0]
	{
		UNIT_ICACHE = 2'd0,
		UNIT_DCACHE = 2'd1,
		UNIT_STBUF = 2'd2
	} unit_e;

	// Command from the dcache pipeline, at most one of store and flush is set
	typedef struct packed
	{
		logic store;
		logic flush;
		logic synchronized;
		logic [STRAND_W-1:0] strand;
		logic [TAG_W-1:0] tag;
		logic [SET_W-1:0] set;
		logic [LINE_W-1:0] data;
		logic [LINE_BYTES-1:0] mask;
	} store_cmd_t;

	typedef struct packed
	{
		unit_e unit;
		logic [STRAND_W-1:0] strand;
		l2_op_e op;
		logic [ADDR_W-1:0] address;
		logic [LINE_W-1:0] data;
		logic [LINE_BYTES-1:0] mask;
	} l2_req_t;

	// Status carries the success flag of a synchronized store
	typedef struct packed
	{
		logic valid;
		logic status;
		unit_e unit;
		logic [STRAND_W-1:0] strand;
		logic update;
	} l2_rsp_t;

	// One pending store or flush held for a strand
	typedef struct packed
	{
		logic [TAG_W-1:0] tag;
		logic [SET_W-1:0] set;
		logic [LINE_W-1:0] data;
		logic [LINE_BYTES-1:0] mask;
		logic synchronized;
		logic flush;
	} stbuf_entry_t;

endpackage

`default_nettype wire

// ==== verilog/store_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_buffer
(
	input wire logic clk,
	input wire logic reset,
	input wire stbuf_pkg::store_cmd_t cmd_i,
	input wire stbuf_pkg::l2_rsp_t l2rsp_i,
	input wire logic sync_enqueue_i,
	input wire logic sync_rollback_i,
	input wire logic [stbuf_pkg::NUM_STRANDS-1:0] resume_sync_i,
	input wire logic [stbuf_pkg::NUM_STRANDS-1:0] grant_oh_i,
	input wire logic l2req_ready_i,
	output logic [stbuf_pkg::NUM_STRANDS-1:0] request_o,
	output logic l2req_valid_o,
	output stbuf_pkg::l2_req_t l2req_o,
	output stbuf_pkg::stbuf_entry_t entries_o [stbuf_pkg::NUM_STRANDS],
	output logic [stbuf_pkg::NUM_STRANDS-1:0] valid_o,
	output logic rollback_o,
	output logic [stbuf_pkg::NUM_STRANDS-1:0] resume_strands_o,
	output logic store_update_o,
	output logic [stbuf_pkg::SET_W-1:0] store_update_set_o
);
	import stbuf_pkg::*;

	stbuf_entry_t entry_q [NUM_STRANDS];
	// Entry holds a store or flush
	logic [NUM_STRANDS-1:0] enqueued_q;
	// L2 has taken the entry and a response is due
	logic [NUM_STRANDS-1:0] acked_q;
	// Strands rolled back because their entry was occupied
	logic [NUM_STRANDS-1:0] full_wait_q;
	logic full_rollback_q;
	logic [STRAND_W-1:0] issue_idx;
	stbuf_entry_t issue_entry;
	logic rsp_hit;
	logic [NUM_STRANDS-1:0] finish_mask;
	logic complete;
	logic cmd_any;
	logic collision;
	logic strand_busy;
	logic enqueue;
	logic accept;

	// Entries still waiting to be sent to L2
	assign request_o = enqueued_q & ~acked_q;
	assign l2req_valid_o = |grant_oh_i;
	assign accept = l2req_valid_o && l2req_ready_i;

	always_comb
	begin
		issue_idx = '0;
		for (int i = 0; i < NUM_STRANDS; i++)
		begin
			if (grant_oh_i[i])
				issue_idx = STRAND_W'(i);
		end
		issue_entry = entry_q[issue_idx];
	end

	always_comb
	begin
		l2req_o.unit = UNIT_STBUF;
		l2req_o.strand = issue_idx;
		// A flush never carries the sync flag, but it wins if both were set
		if (issue_entry.flush)
			l2req_o.op = L2OP_FLUSH;
		else if (issue_entry.synchronized)
			l2req_o.op = L2OP_STORE_SYNC;
		else
			l2req_o.op = L2OP_STORE;
		l2req_o.address = {issue_entry.tag, issue_entry.set};
		l2req_o.data = issue_entry.data;
		l2req_o.mask = issue_entry.mask;
	end

	assign rsp_hit = l2rsp_i.valid && l2rsp_i.unit == UNIT_STBUF;
	assign finish_mask = rsp_hit ? (NUM_STRANDS'(1) << l2rsp_i.strand) : '0;
	assign complete = rsp_hit && enqueued_q[l2rsp_i.strand];

	// A command on a strand whose entry retires this same cycle may take the slot
	assign cmd_any = cmd_i.store || cmd_i.flush;
	assign collision = complete && cmd_any && cmd_i.strand == l2rsp_i.strand;
	assign strand_busy = enqueued_q[cmd_i.strand] && !collision;
	assign enqueue = cmd_any && !strand_busy
		&& (!(cmd_i.store && cmd_i.synchronized) || sync_enqueue_i);

	// The L1 line is refreshed from L2 data when the response says so
	assign store_update_o = complete && l2rsp_i.update;
	assign store_update_set_o = rsp_hit ? entry_q[l2rsp_i.strand].set : '0;

	assign rollback_o = full_rollback_q || sync_rollback_i;
	assign entries_o = entry_q;
	assign valid_o = enqueued_q;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_STRANDS; i++)
				entry_q[i] <= '0;
			enqueued_q <= '0;
			acked_q <= '0;
			full_wait_q <= '0;
			full_rollback_q <= 1'b0;
			resume_strands_o <= '0;
		end
		else
		begin
			// An occupied strand is rolled back and remembered until its entry retires
			if (cmd_any && strand_busy)
			begin
				full_wait_q <= (full_wait_q & ~finish_mask) | (NUM_STRANDS'(1) << cmd_i.strand);
				full_rollback_q <= 1'b1;
			end
			else
			begin
				full_wait_q <= full_wait_q & ~finish_mask;
				full_rollback_q <= 1'b0;
			end

			// Resume lands a cycle after the response so it follows the rollback
			resume_strands_o <= (finish_mask & full_wait_q) | resume_sync_i;

			if (accept)
				acked_q[issue_idx] <= 1'b1;

			if (complete)
			begin
				enqueued_q[l2rsp_i.strand] <= 1'b0;
				acked_q[l2rsp_i.strand] <= 1'b0;
			end

			// Placed after the retire so a colliding command keeps the slot
			if (enqueue)
			begin
				entry_q[cmd_i.strand] <= '{tag: cmd_i.tag, set: cmd_i.set, data: cmd_i.data,
					mask: cmd_i.mask, synchronized: cmd_i.synchronized, flush: cmd_i.flush};
				enqueued_q[cmd_i.strand] <= 1'b1;
			end
		end
	end

	a_rsp_acked: assert property (@(posedge clk) disable iff (reset)
		rsp_hit |-> acked_q[l2rsp_i.strand]);

	a_accept_complete: assert property (@(posedge clk) disable iff (reset)
		!(accept && complete && issue_idx == l2rsp_i.strand));

endmodule

`default_nettype wire

// ==== verilog/store_bypass.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_bypass
(
	input wire logic clk,
	input wire logic reset,
	input wire stbuf_pkg::store_cmd_t cmd_i,
	input wire logic [stbuf_pkg::STRAND_W-1:0] lookup_strand_i,
	input wire logic [stbuf_pkg::TAG_W-1:0] lookup_tag_i,
	input wire logic [stbuf_pkg::SET_W-1:0] lookup_set_i,
	input wire stbuf_pkg::stbuf_entry_t entries_i [stbuf_pkg::NUM_STRANDS],
	input wire logic [stbuf_pkg::NUM_STRANDS-1:0] valid_i,
	input wire logic [stbuf_pkg::NUM_STRANDS-1:0] sync_result_i,
	output logic [stbuf_pkg::LINE_W-1:0] data_o,
	output logic [stbuf_pkg::LINE_BYTES-1:0] mask_o
);
	import stbuf_pkg::*;

	stbuf_entry_t own_entry;
	logic hit;
	logic sync_store;
	logic [WORD_W-1:0] status_word;

	// Only the looking-up strand's own entry can supply bypass data,
	// other strands see memory order through L2
	always_comb
	begin
		own_entry = entries_i[lookup_strand_i];
		hit = valid_i[lookup_strand_i]
			&& own_entry.tag == lookup_tag_i
			&& own_entry.set == lookup_set_i;
	end

	assign sync_store = cmd_i.store && cmd_i.synchronized;

	// The success flag sits in bit 0 of each word so any load width sees it
	assign status_word = {{(WORD_W-1){1'b0}}, sync_result_i[cmd_i.strand]};

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			data_o <= '0;
			mask_o <= '0;
		end
		else if (sync_store)
		begin
			// A sync store returns its L2 status as if it were load data
			data_o <= {LINE_WORDS{status_word}};
			mask_o <= '1;
		end
		else if (hit)
		begin
			data_o <= own_entry.data;
			mask_o <= own_entry.mask;
		end
		else
		begin
			data_o <= '0;
			mask_o <= '0;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/store_subsystem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_subsystem_top
(
	input wire logic clk,
	input wire logic reset,
	input wire stbuf_pkg::store_cmd_t cmd_i,
	input wire logic [stbuf_pkg::STRAND_W-1:0] lookup_strand_i,
	input wire logic [stbuf_pkg::TAG_W-1:0] lookup_tag_i,
	input wire logic [stbuf_pkg::SET_W-1:0] lookup_set_i,
	output logic l2req_valid_o,
	output stbuf_pkg::l2_req_t l2req_o,
	input wire logic l2req_ready_i,
	input wire stbuf_pkg::l2_rsp_t l2rsp_i,
	output logic rollback_o,
	output logic [stbuf_pkg::NUM_STRANDS-1:0] resume_strands_o,
	output logic store_update_o,
	output logic [stbuf_pkg::SET_W-1:0] store_update_set_o,
	output logic [stbuf_pkg::LINE_W-1:0] bypass_data_o,
	output logic [stbuf_pkg::LINE_BYTES-1:0] bypass_mask_o
);
	import stbuf_pkg::*;

	logic [NUM_STRANDS-1:0] request;
	logic [NUM_STRANDS-1:0] grant_oh;
	stbuf_entry_t entries [NUM_STRANDS];
	logic [NUM_STRANDS-1:0] entry_valid;
	logic sync_enqueue;
	logic sync_rollback;
	logic [NUM_STRANDS-1:0] resume_sync;
	logic [NUM_STRANDS-1:0] sync_result;

	store_buffer u_buffer
	(
		.clk(clk),
		.reset(reset),
		.cmd_i(cmd_i),
		.l2rsp_i(l2rsp_i),
		.sync_enqueue_i(sync_enqueue),
		.sync_rollback_i(sync_rollback),
		.resume_sync_i(resume_sync),
		.grant_oh_i(grant_oh),
		.l2req_ready_i(l2req_ready_i),
		.request_o(request),
		.l2req_valid_o(l2req_valid_o),
		.l2req_o(l2req_o),
		.entries_o(entries),
		.valid_o(entry_valid),
		.rollback_o(rollback_o),
		.resume_strands_o(resume_strands_o),
		.store_update_o(store_update_o),
		.store_update_set_o(store_update_set_o)
	);

	// Ready alone is enough here, the arbiter only rotates when it has a grant
	rr_arbiter u_arbiter
	(
		.clk(clk),
		.reset(reset),
		.request_i(request),
		.accept_i(l2req_ready_i),
		.grant_oh_o(grant_oh)
	);

	store_bypass u_bypass
	(
		.clk(clk),
		.reset(reset),
		.cmd_i(cmd_i),
		.lookup_strand_i(lookup_strand_i),
		.lookup_tag_i(lookup_tag_i),
		.lookup_set_i(lookup_set_i),
		.entries_i(entries),
		.valid_i(entry_valid),
		.sync_result_i(sync_result),
		.data_o(bypass_data_o),
		.mask_o(bypass_mask_o)
	);

	sync_store_tracker u_sync
	(
		.clk(clk),
		.reset(reset),
		.cmd_i(cmd_i),
		.entry_busy_i(entry_valid),
		.l2rsp_i(l2rsp_i),
		.sync_enqueue_o(sync_enqueue),
		.sync_rollback_o(sync_rollback),
		.resume_sync_o(resume_sync),
		.sync_result_o(sync_result)
	);

endmodule

`default_nettype wire

// ==== verilog/sync_store_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync_store_tracker
(
	input wire logic clk,
	input wire logic reset,
	input wire stbuf_pkg::store_cmd_t cmd_i,
	input wire logic [stbuf_pkg::NUM_STRANDS-1:0] entry_busy_i,
	input wire stbuf_pkg::l2_rsp_t l2rsp_i,
	output logic sync_enqueue_o,
	output logic sync_rollback_o,
	output logic [stbuf_pkg::NUM_STRANDS-1:0] resume_sync_o,
	output logic [stbuf_pkg::NUM_STRANDS-1:0] sync_result_o
);
	import stbuf_pkg::*;

	// Strands whose sync store is in flight to L2
	logic [NUM_STRANDS-1:0] wait_q;
	// Strands whose sync store was answered and whose retry has not come yet
	logic [NUM_STRANDS-1:0] complete_q;
	logic [NUM_STRANDS-1:0] result_q;
	logic rsp_hit;
	logic strand_free;
	logic [NUM_STRANDS-1:0] rsp_mask;
	logic [NUM_STRANDS-1:0] req_mask;
	logic first_attempt;

	assign rsp_hit = l2rsp_i.valid && l2rsp_i.unit == UNIT_STBUF;
	assign rsp_mask = rsp_hit ? (NUM_STRANDS'(1) << l2rsp_i.strand) : '0;

	// An entry that completes in this cycle counts as free, matching the buffer's
	// collision rule, so the sync store is not dropped
	assign strand_free = !entry_busy_i[cmd_i.strand]
		|| (rsp_hit && l2rsp_i.strand == cmd_i.strand);

	assign req_mask = (cmd_i.store && cmd_i.synchronized && strand_free)
		? (NUM_STRANDS'(1) << cmd_i.strand) : '0;

	// A strand without a stored answer must go to L2 and then retry
	assign first_attempt = |(req_mask & ~complete_q);
	assign sync_enqueue_o = first_attempt;

	// The strand restarts when L2 answers its sync store
	assign resume_sync_o = rsp_mask & wait_q;
	assign sync_result_o = result_q;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wait_q <= '0;
			complete_q <= '0;
			result_q <= '0;
			sync_rollback_o <= 1'b0;
		end
		else
		begin
			// A sync store that takes a slot retiring this cycle starts a fresh wait
			wait_q <= (wait_q & ~rsp_mask) | (req_mask & ~complete_q);
			// The retry consumes the answer so the next sync store goes to L2 again
			complete_q <= (complete_q | (wait_q & rsp_mask)) & ~req_mask;
			if (|(wait_q & rsp_mask))
				result_q[l2rsp_i.strand] <= l2rsp_i.status;
			sync_rollback_o <= first_attempt;
		end
	end

	a_wait_complete_excl: assert property (@(posedge clk) disable iff (reset)
		(wait_q & complete_q) == '0);

	// A strand in wait was rolled back, so the dcache must not issue for it
	a_no_store_while_wait: assert property (@(posedge clk) disable iff (reset)
		(wait_q & req_mask) == '0);

endmodule

`default_nettype wire
